// ==== hdl/rr_bridge_consts.svh ====
`ifndef RR_BRIDGE_CONSTS_SVH
`define RR_BRIDGE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Channel payload widths
////////////////////////////////////////////////////////////
// Channel 0 carries full words
`define RR_CH0_W 32
// Channel 1 carries half words
`define RR_CH1_W 16

////////////////////////////////////////////////////////////
// Trace format
////////////////////////////////////////////////////////////
// Trace payload is as wide as the widest channel
`define RR_TRACE_W 32
// Number of traced channels
`define RR_NUM_CH 2
// Width of the channel id carried with every entry
`define RR_ID_W 1

`endif

// ==== hdl/rr_bridge_pkg.sv ====
package rr_bridge_pkg;

  `include "rr_bridge_consts.svh"

  ////////////////////////////////////////////////////////////
  // Payload types of the two host/user channels
  ////////////////////////////////////////////////////////////
  // Channel 0 word
  typedef logic [`RR_CH0_W-1:0] ch0_data_t;
  // Channel 1 word
  typedef logic [`RR_CH1_W-1:0] ch1_data_t;

  ////////////////////////////////////////////////////////////
  // Trace entry fields
  ////////////////////////////////////////////////////////////
  // Payload of a trace entry, narrow channels zero-extended
  typedef logic [`RR_TRACE_W-1:0] trace_data_t;
  // Channel id of a trace entry
  // Channel 0 is id 0 and channel 1 is id 1
  typedef logic [`RR_ID_W-1:0] chan_id_t;

endpackage

// ==== hdl/rr_trace_split.sv ====
`include "rr_bridge_consts.svh"

module rr_trace_split import rr_bridge_pkg::*; (
  input  logic        clk,
  input  logic        i_arst_n,
  // Replay trace input
  input  logic        i_replay_valid,
  input  chan_id_t    i_replay_id,
  input  trace_data_t i_replay_data,
  output logic        o_replay_ready,
  // Replay stream toward channel 0
  output logic        o_rep0_valid,
  output ch0_data_t   o_rep0_data,
  input  logic        i_rep0_ready,
  // Replay stream toward channel 1
  output logic        o_rep1_valid,
  output ch1_data_t   o_rep1_data,
  input  logic        i_rep1_ready
);

  // Holding register for one replay entry
  logic                  r_valid;
  chan_id_t              r_id;
  trace_data_t           r_data;
  // One-hot channel select decoded from the held id
  logic [`RR_NUM_CH-1:0] sel_onehot;
  // Readies of all channel streams
  logic [`RR_NUM_CH-1:0] rdy_vec;
  // Held entry leaves this cycle
  logic                  drain;

  ////////////////////////////////////////////////////////////
  // Channel decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    sel_onehot       = '0;
    sel_onehot[r_id] = 1'b1;
  end

  assign rdy_vec = {i_rep1_ready, i_rep0_ready};
  assign drain   = r_valid && |(sel_onehot & rdy_vec);

  // Take a new entry when empty or emptying
  assign o_replay_ready = !r_valid || drain;

  ////////////////////////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////////////////////////
  // Control state only
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= 1'b0;
    end else if (o_replay_ready) begin
      r_valid <= i_replay_valid;
    end
  end

  // Id and payload follow the accepted entry
  always_ff @(posedge clk) begin
    if (o_replay_ready && i_replay_valid) begin
      r_id   <= i_replay_id;
      r_data <= i_replay_data;
    end
  end

  // Only the addressed channel sees valid
  assign o_rep0_valid = r_valid && sel_onehot[0];
  assign o_rep1_valid = r_valid && sel_onehot[1];
  // Truncate to each channel width
  assign o_rep0_data  = ch0_data_t'(r_data);
  assign o_rep1_data  = ch1_data_t'(r_data);

endmodule

// ==== hdl/rr_chan_recorder.sv ====
module rr_chan_recorder import rr_bridge_pkg::*; #(
  // Payload of the channel served by this instance
  parameter type      payload_t = ch0_data_t,
  // Id written into every log entry of this channel
  parameter chan_id_t CHAN_ID   = '0
) (
  input  logic        clk,
  input  logic        i_arst_n,
  // Mode inputs, quasi-static
  input  logic        i_record_en,
  input  logic        i_replay_en,
  // Host side stream
  input  logic        i_host_valid,
  input  payload_t    i_host_data,
  output logic        o_host_ready,
  // Replay side stream
  input  logic        i_rep_valid,
  input  payload_t    i_rep_data,
  output logic        o_rep_ready,
  // User side stream
  output logic        o_user_valid,
  output payload_t    o_user_data,
  input  logic        i_user_ready,
  // Log entry toward the trace merger
  output logic        o_log_valid,
  output chan_id_t    o_log_id,
  output trace_data_t o_log_data,
  input  logic        i_log_ready
);

  // Selected source stream
  logic        src_valid;
  payload_t    src_data;
  logic        src_ready;
  // Space in the output registers
  logic        user_can;
  logic        log_can;
  // A word is taken from the source this cycle
  logic        accept;
  // User side register slice
  logic        u_valid;
  payload_t    u_data;
  // Log entry register
  logic        l_valid;
  trace_data_t l_data;

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////
  // Replay mode drives the user side from the trace
  assign src_valid = i_replay_en ? i_rep_valid : i_host_valid;
  assign src_data  = i_replay_en ? i_rep_data : i_host_data;

  // Each register can take a word when empty or emptying
  assign user_can  = !u_valid || i_user_ready;
  assign log_can   = !l_valid || i_log_ready;
  // Log side back-pressure only counts while recording
  assign src_ready = user_can && (!i_record_en || log_can);
  assign accept    = src_valid && src_ready;

  // The unselected stream sees ready held low
  assign o_host_ready = src_ready && !i_replay_en;
  assign o_rep_ready  = src_ready && i_replay_en;

  ////////////////////////////////////////////////////////////
  // User register slice
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      u_valid <= 1'b0;
    end else if (accept) begin
      u_valid <= 1'b1;
    end else if (i_user_ready) begin
      u_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      u_data <= src_data;
    end
  end

  assign o_user_valid = u_valid;
  assign o_user_data  = u_data;

  ////////////////////////////////////////////////////////////
  // Log entry capture
  ////////////////////////////////////////////////////////////
  // Entry shows up together with the user word
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      l_valid <= 1'b0;
    end else if (accept && i_record_en) begin
      l_valid <= 1'b1;
    end else if (i_log_ready) begin
      l_valid <= 1'b0;
    end
  end

  // Zero-extend narrow payloads to trace width
  always_ff @(posedge clk) begin
    if (accept && i_record_en) begin
      l_data <= trace_data_t'(src_data);
    end
  end

  assign o_log_valid = l_valid;
  assign o_log_id    = CHAN_ID;
  assign o_log_data  = l_data;

endmodule

// ==== hdl/rr_trace_merge.sv ====
module rr_trace_merge import rr_bridge_pkg::*; (
  input  logic        clk,
  input  logic        i_arst_n,
  // Log entries from channel 0
  input  logic        i_log0_valid,
  input  chan_id_t    i_log0_id,
  input  trace_data_t i_log0_data,
  output logic        o_log0_ready,
  // Log entries from channel 1
  input  logic        i_log1_valid,
  input  chan_id_t    i_log1_id,
  input  trace_data_t i_log1_data,
  output logic        o_log1_ready,
  // Merged trace output
  output logic        o_trace_valid,
  output chan_id_t    o_trace_id,
  output trace_data_t o_trace_data,
  input  logic        i_trace_ready
);

  // Output register
  logic        t_valid;
  chan_id_t    t_id;
  trace_data_t t_data;
  // Output register can take an entry
  logic        out_free;
  // Grants of this cycle
  logic        gnt0;
  logic        gnt1;
  // Set when channel 1 won the last grant
  logic        last_q;

  ////////////////////////////////////////////////////////////
  // Round-robin arbiter
  ////////////////////////////////////////////////////////////
  // A stalled trace output blocks any new grant
  assign out_free = !t_valid || i_trace_ready;

  // Alone wins, or the other side went last
  assign gnt0 = out_free && i_log0_valid && (!i_log1_valid || last_q);
  assign gnt1 = out_free && i_log1_valid && (!i_log0_valid || !last_q);

  assign o_log0_ready = gnt0;
  assign o_log1_ready = gnt1;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      last_q <= 1'b0;
    end else if (gnt0 || gnt1) begin
      last_q <= gnt1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Trace output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      t_valid <= 1'b0;
    end else if (gnt0 || gnt1) begin
      t_valid <= 1'b1;
    end else if (i_trace_ready) begin
      t_valid <= 1'b0;
    end
  end

  // Granted entry, one cycle after its handshake
  always_ff @(posedge clk) begin
    if (gnt1) begin
      t_id   <= i_log1_id;
      t_data <= i_log1_data;
    end else if (gnt0) begin
      t_id   <= i_log0_id;
      t_data <= i_log0_data;
    end
  end

  assign o_trace_valid = t_valid;
  assign o_trace_id    = t_id;
  assign o_trace_data  = t_data;

endmodule

// ==== hdl/rr_bridge_top.sv ====
module rr_bridge_top import rr_bridge_pkg::*; (
  input  logic        clk,
  input  logic        i_arst_n,
  // Mode, changed only while idle
  input  logic        i_record_en,
  input  logic        i_replay_en,
  // Host channel 0
  input  logic        i_host0_valid,
  input  ch0_data_t   i_host0_data,
  output logic        o_host0_ready,
  // Host channel 1
  input  logic        i_host1_valid,
  input  ch1_data_t   i_host1_data,
  output logic        o_host1_ready,
  // User channel 0
  output logic        o_user0_valid,
  output ch0_data_t   o_user0_data,
  input  logic        i_user0_ready,
  // User channel 1
  output logic        o_user1_valid,
  output ch1_data_t   o_user1_data,
  input  logic        i_user1_ready,
  // Recorded trace
  output logic        o_trace_valid,
  output chan_id_t    o_trace_id,
  output trace_data_t o_trace_data,
  input  logic        i_trace_ready,
  // Trace to replay
  input  logic        i_replay_valid,
  input  chan_id_t    i_replay_id,
  input  trace_data_t i_replay_data,
  output logic        o_replay_ready
);

  ////////////////////////////////////////////////////////////
  // Internal streams
  ////////////////////////////////////////////////////////////
  // Replay words already cut to channel width
  logic        rep0_valid;
  ch0_data_t   rep0_data;
  logic        rep0_ready;
  logic        rep1_valid;
  ch1_data_t   rep1_data;
  logic        rep1_ready;
  // Per-channel log entries
  logic        log0_valid;
  chan_id_t    log0_id;
  trace_data_t log0_data;
  logic        log0_ready;
  logic        log1_valid;
  chan_id_t    log1_id;
  trace_data_t log1_data;
  logic        log1_ready;

  // Input side splits replay entries by id
  rr_trace_split rr_trace_split_i (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_replay_valid (i_replay_valid),
    .i_replay_id    (i_replay_id),
    .i_replay_data  (i_replay_data),
    .o_replay_ready (o_replay_ready),
    .o_rep0_valid   (rep0_valid),
    .o_rep0_data    (rep0_data),
    .i_rep0_ready   (rep0_ready),
    .o_rep1_valid   (rep1_valid),
    .o_rep1_data    (rep1_data),
    .i_rep1_ready   (rep1_ready)
  );

  ////////////////////////////////////////////////////////////
  // Channel recorders
  ////////////////////////////////////////////////////////////
  rr_chan_recorder #(
    .payload_t (ch0_data_t),
    .CHAN_ID   (1'b0)
  ) rr_chan_recorder0_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_record_en  (i_record_en),
    .i_replay_en  (i_replay_en),
    .i_host_valid (i_host0_valid),
    .i_host_data  (i_host0_data),
    .o_host_ready (o_host0_ready),
    .i_rep_valid  (rep0_valid),
    .i_rep_data   (rep0_data),
    .o_rep_ready  (rep0_ready),
    .o_user_valid (o_user0_valid),
    .o_user_data  (o_user0_data),
    .i_user_ready (i_user0_ready),
    .o_log_valid  (log0_valid),
    .o_log_id     (log0_id),
    .o_log_data   (log0_data),
    .i_log_ready  (log0_ready)
  );

  rr_chan_recorder #(
    .payload_t (ch1_data_t),
    .CHAN_ID   (1'b1)
  ) rr_chan_recorder1_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_record_en  (i_record_en),
    .i_replay_en  (i_replay_en),
    .i_host_valid (i_host1_valid),
    .i_host_data  (i_host1_data),
    .o_host_ready (o_host1_ready),
    .i_rep_valid  (rep1_valid),
    .i_rep_data   (rep1_data),
    .o_rep_ready  (rep1_ready),
    .o_user_valid (o_user1_valid),
    .o_user_data  (o_user1_data),
    .i_user_ready (i_user1_ready),
    .o_log_valid  (log1_valid),
    .o_log_id     (log1_id),
    .o_log_data   (log1_data),
    .i_log_ready  (log1_ready)
  );

  // Output side merges both logs onto the trace
  rr_trace_merge rr_trace_merge_i (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_log0_valid  (log0_valid),
    .i_log0_id     (log0_id),
    .i_log0_data   (log0_data),
    .o_log0_ready  (log0_ready),
    .i_log1_valid  (log1_valid),
    .i_log1_id     (log1_id),
    .i_log1_data   (log1_data),
    .o_log1_ready  (log1_ready),
    .o_trace_valid (o_trace_valid),
    .o_trace_id    (o_trace_id),
    .o_trace_data  (o_trace_data),
    .i_trace_ready (i_trace_ready)
  );

endmodule

// ==== test/rr_bridge_assert.sv ====
module rr_bridge_assert import rr_bridge_pkg::*; (
  input logic        clk,
  input logic        i_arst_n,
  input logic        i_replay_en,
  input logic        o_host0_ready,
  input logic        o_host1_ready,
  input logic        o_user0_valid,
  input ch0_data_t   o_user0_data,
  input logic        i_user0_ready,
  input logic        o_user1_valid,
  input ch1_data_t   o_user1_data,
  input logic        i_user1_ready,
  input logic        o_trace_valid,
  input chan_id_t    o_trace_id,
  input trace_data_t o_trace_data,
  input logic        i_trace_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions, read by the testbench
  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Stream stability while stalled
  ////////////////////////////////////////////////////////////
  trace_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_trace_valid && !i_trace_ready |=>
      o_trace_valid && $stable(o_trace_id) && $stable(o_trace_data))
    else begin
      $error("trace entry changed while stalled");
      fail_cnt++;
    end

  user0_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_user0_valid && !i_user0_ready |=> o_user0_valid && $stable(o_user0_data))
    else begin
      $error("user channel 0 word changed while stalled");
      fail_cnt++;
    end

  user1_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_user1_valid && !i_user1_ready |=> o_user1_valid && $stable(o_user1_data))
    else begin
      $error("user channel 1 word changed while stalled");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Mode and reset
  ////////////////////////////////////////////////////////////
  // Host side is locked out during replay
  host_locked: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_replay_en |-> !o_host0_ready && !o_host1_ready)
    else begin
      $error("host ready high in replay mode");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk)
    !i_arst_n |-> !o_user0_valid && !o_user1_valid && !o_trace_valid)
    else begin
      $error("valid output high during reset");
      fail_cnt++;
    end

endmodule

bind rr_bridge_top rr_bridge_assert rr_bridge_assert_i (.*);

// ==== test/rr_bridge_tb.sv ====
module rr_bridge_tb import rr_bridge_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Words per host channel in each host test, entries in the replay test
  localparam int N_WORDS  = 200;
  localparam int N_REPLAY = 400;
  localparam int N_XFER   = 6 * N_WORDS + N_REPLAY;
  localparam int TIMEOUT  = 8 * N_XFER + 1000;

  // DUT ports, same names as on the top level
  logic        clk;
  logic        i_arst_n;
  logic        i_record_en;
  logic        i_replay_en;
  logic        i_host0_valid;
  ch0_data_t   i_host0_data;
  logic        o_host0_ready;
  logic        i_host1_valid;
  ch1_data_t   i_host1_data;
  logic        o_host1_ready;
  logic        o_user0_valid;
  ch0_data_t   o_user0_data;
  logic        i_user0_ready;
  logic        o_user1_valid;
  ch1_data_t   o_user1_data;
  logic        i_user1_ready;
  logic        o_trace_valid;
  chan_id_t    o_trace_id;
  trace_data_t o_trace_data;
  logic        i_trace_ready;
  logic        i_replay_valid;
  chan_id_t    i_replay_id;
  trace_data_t i_replay_data;
  logic        o_replay_ready;

  // Reference model, expected results per channel
  ch0_data_t   exp_u0[$];
  ch1_data_t   exp_u1[$];
  trace_data_t exp_t0[$];
  trace_data_t exp_t1[$];

  integer seed = 32'h6cef;
  int     cycles = 0;
  int     mon_errors = 0;
  int     run_errors = 0;
  int     err_mark = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  // Remaining low cycles of a ready stall, user0 user1 trace
  int     stretch [3] = '{0, 0, 0};
  // Handshakes seen in the middle of the last cycle
  logic   hs0 = 1'b0;
  logic   hs1 = 1'b0;
  logic   hsr = 1'b0;

  rr_bridge_top rr_bridge_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d user and %0d trace results still missing",
               cycles, exp_u0.size() + exp_u1.size(), exp_t0.size() + exp_t1.size());
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks, one per result type
  ////////////////////////////////////////////////////////////
  task automatic check_ch0(input string name, input ch0_data_t got, input ch0_data_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
      mon_errors++;
    end
  endtask

  task automatic check_ch1(input string name, input ch1_data_t got, input ch1_data_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
      mon_errors++;
    end
  endtask

  task automatic check_trace_id(input string name, input chan_id_t got, input chan_id_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
      mon_errors++;
    end
  endtask

  task automatic check_trace_data(input string name, input trace_data_t got,
                                  input trace_data_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
      mon_errors++;
    end
  endtask

  function automatic int total_errors();
    return mon_errors + run_errors + rr_bridge_top_i.rr_bridge_assert_i.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor and model, sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    chan_id_t want_id;
    hs0 = i_host0_valid && o_host0_ready;
    hs1 = i_host1_valid && o_host1_ready;
    hsr = i_replay_valid && o_replay_ready;
    if (i_arst_n) begin
      // Accepted host words go to the user side, and to the trace when recording
      if (hs0) begin
        exp_u0.push_back(i_host0_data);
        if (i_record_en)
          exp_t0.push_back(trace_data_t'(i_host0_data));
      end
      if (hs1) begin
        exp_u1.push_back(i_host1_data);
        if (i_record_en)
          exp_t1.push_back(trace_data_t'(i_host1_data));
      end
      // Replay entries cut to channel width, traced again zero-extended
      if (hsr && i_replay_id == 1'b0) begin
        exp_u0.push_back(ch0_data_t'(i_replay_data));
        if (i_record_en)
          exp_t0.push_back(trace_data_t'(ch0_data_t'(i_replay_data)));
      end
      if (hsr && i_replay_id == 1'b1) begin
        exp_u1.push_back(ch1_data_t'(i_replay_data));
        if (i_record_en)
          exp_t1.push_back(trace_data_t'(ch1_data_t'(i_replay_data)));
      end
      if (i_replay_en && (o_host0_ready || o_host1_ready)) begin
        $display("Host ready is high while replay is enabled");
        mon_errors++;
      end
      if (o_user0_valid && i_user0_ready) begin
        if (exp_u0.size() == 0) begin
          $display("Unexpected word 0x%h on user channel 0", o_user0_data);
          mon_errors++;
        end else begin
          check_ch0("o_user0_data", o_user0_data, exp_u0.pop_front());
        end
      end
      if (o_user1_valid && i_user1_ready) begin
        if (exp_u1.size() == 0) begin
          $display("Unexpected word 0x%h on user channel 1", o_user1_data);
          mon_errors++;
        end else begin
          check_ch1("o_user1_data", o_user1_data, exp_u1.pop_front());
        end
      end
      // Order across channels is free, the id picks the channel queue
      if (o_trace_valid && i_trace_ready) begin
        want_id = o_trace_id;
        if (o_trace_id == 1'b0 && exp_t0.size() == 0)
          want_id = 1'b1;
        if (o_trace_id == 1'b1 && exp_t1.size() == 0)
          want_id = 1'b0;
        if (exp_t0.size() == 0 && exp_t1.size() == 0) begin
          $display("Unexpected trace entry id %0d data 0x%h", o_trace_id, o_trace_data);
          mon_errors++;
        end else begin
          check_trace_id("o_trace_id", o_trace_id, want_id);
          if (want_id == 1'b0)
            check_trace_data("o_trace_data", o_trace_data, exp_t0.pop_front());
          else
            check_trace_data("o_trace_data", o_trace_data, exp_t1.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  // Random ready with occasional long low stretches
  function automatic logic next_ready(input int k, input logic bp);
    if (!bp)
      return 1'b1;
    if (stretch[k] > 0) begin
      stretch[k]--;
      return 1'b0;
    end
    if (($random(seed) & 31) == 0)
      stretch[k] = 8 + ($random(seed) & 31);
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic drive_traffic(input int n_host, input int n_rep, input logic bp);
    int sent0 = 0;
    int sent1 = 0;
    int sentr = 0;
    while (sent0 < n_host || sent1 < n_host || sentr < n_rep ||
           i_host0_valid || i_host1_valid || i_replay_valid) begin
      @(posedge clk);
      #1;
      i_user0_ready = next_ready(0, bp);
      i_user1_ready = next_ready(1, bp);
      i_trace_ready = next_ready(2, bp);
      // New word only once the previous one was taken
      if (!i_host0_valid || hs0) begin
        i_host0_valid = sent0 < n_host && ($random(seed) & 3) != 0;
        i_host0_data  = $random(seed);
        if (i_host0_valid)
          sent0++;
      end
      if (!i_host1_valid || hs1) begin
        i_host1_valid = sent1 < n_host && ($random(seed) & 3) != 0;
        i_host1_data  = ch1_data_t'($random(seed));
        if (i_host1_valid)
          sent1++;
      end
      if (!i_replay_valid || hsr) begin
        i_replay_valid = sentr < n_rep && ($random(seed) & 3) != 0;
        i_replay_id    = 1'($random(seed));
        i_replay_data  = $random(seed);
        if (i_replay_valid)
          sentr++;
      end
    end
  endtask

  // Open all readies and wait for every expected result
  task automatic drain();
    @(posedge clk);
    #1;
    i_user0_ready = 1'b1;
    i_user1_ready = 1'b1;
    i_trace_ready = 1'b1;
    while (exp_u0.size() != 0 || exp_u1.size() != 0 || exp_t0.size() != 0 ||
           exp_t1.size() != 0 || o_user0_valid || o_user1_valid || o_trace_valid) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name);
    int    n;
    string verdict;
    n = total_errors() - err_mark;
    tests_run++;
    if (n == 0) begin
      verdict = "ok";
    end else begin
      verdict = "not ok";
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests_run, name, verdict, n);
  endtask

  // Mode is set while the bridge is idle
  task automatic run_test(input string name, input logic rec, input logic rep, input logic bp);
    err_mark    = total_errors();
    i_record_en = rec;
    i_replay_en = rep;
    drive_traffic(rep ? 0 : N_WORDS, rep ? N_REPLAY : 0, bp);
    drain();
    end_test(name);
  endtask

  initial begin
    i_arst_n       = 1'b0;
    i_record_en    = 1'b0;
    i_replay_en    = 1'b0;
    i_host0_valid  = 1'b0;
    i_host0_data   = '0;
    i_host1_valid  = 1'b0;
    i_host1_data   = '0;
    i_user0_ready  = 1'b1;
    i_user1_ready  = 1'b1;
    i_trace_ready  = 1'b1;
    i_replay_valid = 1'b0;
    i_replay_id    = '0;
    i_replay_data  = '0;
    repeat (2) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    err_mark = total_errors();
    if (o_user0_valid || o_user1_valid || o_trace_valid) begin
      $display("A valid output is high right after reset");
      run_errors++;
    end
    if (!o_replay_ready) begin
      $display("Replay ready is low right after reset");
      run_errors++;
    end
    end_test("reset");

    run_test("pass-through, record off", 1'b0, 1'b0, 1'b0);
    run_test("record", 1'b1, 1'b0, 1'b0);
    run_test("record with back-pressure", 1'b1, 1'b0, 1'b1);
    run_test("replay with record on", 1'b1, 1'b1, 1'b1);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== rr_bridge.f ====
+incdir+hdl
hdl/rr_bridge_pkg.sv
hdl/rr_trace_split.sv
hdl/rr_chan_recorder.sv
hdl/rr_trace_merge.sv
hdl/rr_bridge_top.sv
test/rr_bridge_assert.sv
test/rr_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the record/replay bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --no-stop-fail \
  --timescale 1ns/100ps \
  --top-module rr_bridge_tb \
  -f rr_bridge.f \
  -o rr_bridge_sim

out="$(./obj_dir/rr_bridge_sim)"
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
else
  exit 1
fi
